//--- logic/lpc_cfg.svh
`ifndef LPC_CFG_SVH
`define LPC_CFG_SVH

`define LPC_ORDER        10
`define LAG_W            16
`define COEF_W           16
`define ACC_W            40
`define COEF_ONE         8192   // 1.0 in Q13
`define LAG_FIFO_DEPTH   16
`define COEF_FIFO_DEPTH  16

`endif

//--- logic/lpc_pkg.sv
`default_nettype none

`include "lpc_cfg.svh"

package lpc_pkg;

  typedef logic signed [`LAG_W-1:0] lag_t;
  typedef logic signed [`COEF_W-1:0] coef_t;   // Q13
  typedef logic signed [`ACC_W-1:0] acc_t;

  // One output beat, value on top
  typedef struct packed {
    coef_t value;
    logic  err;
    logic  last;
  } coef_beat_t;

endpackage

`default_nettype wire

//--- logic/stream_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                   mem [0:DEPTH-1];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(DEPTH));   // Only full blocks
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= bump(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= bump(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/corr_mac.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module corr_mac (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  logic [3:0]     order,
  input  lpc_pkg::lag_t  lags [0:`LPC_ORDER],
  input  lpc_pkg::coef_t coefs [0:`LPC_ORDER],
  output lpc_pkg::acc_t  num,
  output lpc_pkg::acc_t  den,
  output logic           done
);

  import lpc_pkg::*;

  logic [3:0] j;
  logic       busy;
  acc_t       prod_num;
  acc_t       prod_den;

  // Both products are exact in the 40-bit context
  assign prod_num = coefs[j] * lags[order - j];
  assign prod_den = coefs[j] * lags[j];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      j    <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        j    <= '0;
      end else if (busy) begin
        j <= j + 1'b1;
        if (j == order - 4'd1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      num <= '0;
      den <= '0;
    end else if (busy) begin
      num <= num + prod_num;
      den <= den + prod_den;
    end
  end

endmodule

`default_nettype wire

//--- logic/fixed_divider.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module fixed_divider (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  lpc_pkg::acc_t  num,
  input  lpc_pkg::acc_t  den,
  output lpc_pkg::coef_t k,
  output logic           err,
  output logic           done
);

  import lpc_pkg::*;

  localparam int STEPS = 48;
  localparam int DVD_W = `ACC_W + 15;   // |num| * 32768
  localparam int HI_W  = DVD_W - STEPS;

  logic [`ACC_W-1:0] mag_num;
  logic [DVD_W-1:0]  dividend;
  logic [`ACC_W-1:0] rem;
  logic [STEPS-1:0]  q;
  logic [`ACC_W-1:0] cur_rem;
  logic [STEPS-1:0]  cur_q;
  logic [`ACC_W:0]   trial;
  logic [`ACC_W:0]   diff;
  logic              fits;
  logic              sat;
  logic              neg_num;
  logic              busy;
  logic [5:0]        cnt;
  coef_t             k_mag;

  assign mag_num  = num[`ACC_W-1] ? -num : num;
  assign dividend = {mag_num, 15'd0};

  // First step runs on the start cycle itself
  assign cur_rem = start ? `ACC_W'(dividend[DVD_W-1 -: HI_W]) : rem;
  assign cur_q   = start ? dividend[STEPS-1:0] : q;
  assign trial   = {cur_rem, cur_q[STEPS-1]};
  assign diff    = trial - {1'b0, den};
  assign fits    = (trial >= {1'b0, den});

  // Quotient of 2^15 or more clips
  assign k_mag = (sat || (|q[STEPS-1:15])) ? 16'sd32767 : {1'b0, q[14:0]};
  assign k     = neg_num ? k_mag : -k_mag;   // k = -num/den

  always_ff @(posedge clk) begin
    if (start || busy) begin
      rem <= fits ? diff[`ACC_W-1:0] : trial[`ACC_W-1:0];
      q   <= {cur_q[STEPS-2:0], fits};
    end
    if (start) begin
      sat     <= (`ACC_W'(dividend[DVD_W-1 -: HI_W]) >= den);
      neg_num <= num[`ACC_W-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      cnt  <= '0;
      err  <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        cnt  <= '0;
        err  <= (den <= 0);
        busy <= (den > 0);
        done <= (den <= 0);
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == 6'(STEPS - 2)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/coeff_update.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module coeff_update (
  input  logic           clk,
  input  logic           rst,
  input  logic           init,
  input  logic           start,
  input  logic [3:0]     order,
  input  lpc_pkg::coef_t k,
  output lpc_pkg::coef_t coefs [0:`LPC_ORDER],
  output logic           done
);

  import lpc_pkg::*;

  logic [3:0] j;
  logic       busy;
  logic       last_step;

  // a + round(kk * b), clipped to 16 bits
  function automatic coef_t upd(input coef_t a, input coef_t b, input coef_t kk);
    logic signed [31:0] prod;
    logic signed [17:0] sum;
    prod = kk * b + 32'sd16384;
    sum  = a + 18'(prod >>> 15);
    if (sum > 18'sd32767) begin
      return 16'sh7fff;
    end else if (sum < -18'sd32768) begin
      return 16'sh8000;
    end
    return sum[15:0];
  endfunction

  assign last_step = ((5'(j) << 1) >= 5'(order));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      j    <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        j    <= 4'd1;
      end else if (busy) begin
        j <= j + 1'b1;
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i <= `LPC_ORDER; i++) begin
        coefs[i] <= (i == 0) ? coef_t'(`COEF_ONE) : '0;
      end
    end else if (busy) begin
      if (j <= order - j) begin
        coefs[j]         <= upd(coefs[j], coefs[order - j], k);
        coefs[order - j] <= upd(coefs[order - j], coefs[j], k);   // Middle tap hits itself
      end
      if (last_step) begin
        coefs[order] <= k >>> 2;   // Q15 to Q13
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/levinson_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module levinson_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                lag_valid,
  output logic                lag_ready,
  input  lpc_pkg::lag_t       lag_data,
  output logic                beat_valid,
  input  logic                beat_ready,
  output lpc_pkg::coef_beat_t beat_data
);

  import lpc_pkg::*;

  typedef enum logic [2:0] {
    S_LOAD, S_INIT, S_MAC, S_DIV, S_UPD, S_EMIT, S_ERR
  } state_t;

  state_t     state;
  lag_t       lags [0:`LPC_ORDER];
  coef_t      coefs [0:`LPC_ORDER];
  logic [3:0] lag_idx;
  logic [3:0] m;          // Current iteration
  logic [3:0] emit_idx;
  logic       cu_init;
  logic       mac_start;
  logic       mac_done;
  logic       div_start;
  logic       div_done;
  logic       div_err;
  logic       upd_start;
  logic       upd_done;
  acc_t       num;
  acc_t       den;
  coef_t      k;

  assign lag_ready  = (state == S_LOAD);
  assign beat_valid = (state == S_EMIT) || (state == S_ERR);

  always_comb begin
    beat_data.value = coefs[emit_idx];
    beat_data.err   = 1'b0;
    beat_data.last  = (emit_idx == 4'(`LPC_ORDER));
    if (state == S_ERR) begin
      beat_data.value = '0;
      beat_data.err   = 1'b1;
      beat_data.last  = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lag_valid && lag_ready) begin
      lags[lag_idx] <= lag_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_LOAD;
      lag_idx   <= '0;
      m         <= '0;
      emit_idx  <= '0;
      cu_init   <= 1'b0;
      mac_start <= 1'b0;
      div_start <= 1'b0;
      upd_start <= 1'b0;
    end else begin
      cu_init   <= 1'b0;
      mac_start <= 1'b0;
      div_start <= 1'b0;
      upd_start <= 1'b0;
      case (state)
        S_LOAD: if (lag_valid) begin
          lag_idx <= lag_idx + 1'b1;
          if (lag_idx == 4'(`LPC_ORDER)) begin   // R10 in
            lag_idx <= '0;
            m       <= 4'd1;
            cu_init <= 1'b1;
            state   <= S_INIT;
          end
        end
        S_INIT: begin
          mac_start <= 1'b1;
          state     <= S_MAC;
        end
        S_MAC: if (mac_done) begin
          div_start <= 1'b1;
          state     <= S_DIV;
        end
        S_DIV: if (div_done) begin
          if (div_err) begin
            state <= S_ERR;   // Non-positive den, abort frame
          end else begin
            upd_start <= 1'b1;
            state     <= S_UPD;
          end
        end
        S_UPD: if (upd_done) begin
          if (m == 4'(`LPC_ORDER)) begin
            emit_idx <= 4'd1;
            state    <= S_EMIT;
          end else begin
            m         <= m + 1'b1;
            mac_start <= 1'b1;
            state     <= S_MAC;
          end
        end
        S_EMIT: if (beat_ready) begin
          emit_idx <= emit_idx + 1'b1;
          if (beat_data.last) begin
            state <= S_LOAD;
          end
        end
        S_ERR: if (beat_ready) begin
          state <= S_LOAD;
        end
        default: state <= S_LOAD;
      endcase
    end
  end

  corr_mac corr_mac (
    .clk   (clk),
    .rst   (rst),
    .start (mac_start),
    .order (m),
    .lags  (lags),
    .coefs (coefs),
    .num   (num),
    .den   (den),
    .done  (mac_done)
  );

  fixed_divider fixed_divider (
    .clk   (clk),
    .rst   (rst),
    .start (div_start),
    .num   (num),
    .den   (den),
    .k     (k),
    .err   (div_err),
    .done  (div_done)
  );

  coeff_update coeff_update (
    .clk   (clk),
    .rst   (rst),
    .init  (cu_init),
    .start (upd_start),
    .order (m),
    .k     (k),
    .coefs (coefs),
    .done  (upd_done)
  );

endmodule

`default_nettype wire

//--- logic/lpc_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module lpc_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   lag_valid,
  output logic                   lag_ready,
  input  lpc_pkg::lag_t          lag_data,
  output logic                   coef_valid,
  input  logic                   coef_ready,
  output lpc_pkg::coef_beat_t    coef_data
);

  import lpc_pkg::*;

  logic       fifo_lag_valid;
  logic       fifo_lag_ready;
  lag_t       fifo_lag_data;

  logic       solver_beat_valid;
  logic       solver_beat_ready;
  coef_beat_t solver_beat_data;

  // Holds the next frame while the current one is solved
  stream_fifo #(
    .T     (lag_t),
    .DEPTH (`LAG_FIFO_DEPTH)
  ) lag_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (lag_valid),
    .in_ready  (lag_ready),
    .in_data   (lag_data),
    .out_valid (fifo_lag_valid),
    .out_ready (fifo_lag_ready),
    .out_data  (fifo_lag_data)
  );

  levinson_ctrl levinson_ctrl (
    .clk        (clk),
    .rst        (rst),
    .lag_valid  (fifo_lag_valid),
    .lag_ready  (fifo_lag_ready),
    .lag_data   (fifo_lag_data),
    .beat_valid (solver_beat_valid),
    .beat_ready (solver_beat_ready),
    .beat_data  (solver_beat_data)
  );

  // Absorbs output back-pressure
  stream_fifo #(
    .T     (coef_beat_t),
    .DEPTH (`COEF_FIFO_DEPTH)
  ) coef_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (solver_beat_valid),
    .in_ready  (solver_beat_ready),
    .in_data   (solver_beat_data),
    .out_valid (coef_valid),
    .out_ready (coef_ready),
    .out_data  (coef_data)
  );

endmodule

`default_nettype wire

//--- dv/lpc_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module lpc_properties (
  input logic                                      clk,
  input logic                                      rst,
  input logic                                      coef_valid,
  input logic                                      coef_ready,
  input lpc_pkg::coef_beat_t                       coef_data,
  input logic                                      lag_out_valid,
  input logic                                      lag_out_ready,
  input logic [$clog2(`LAG_FIFO_DEPTH + 1)-1:0]    lag_count,
  input logic [$clog2(`COEF_FIFO_DEPTH + 1)-1:0]   beat_count,
  input logic                                      div_start,
  input logic                                      div_done
);

  int   fail_count = 0;
  logic div_open;   // Start seen and done still owed

  always_ff @(posedge clk) begin
    if (rst) begin
      div_open <= 1'b0;
    end else if (div_start) begin
      div_open <= 1'b1;
    end else if (div_done) begin
      div_open <= 1'b0;
    end
  end

  a_coef_hold: assert property (@(posedge clk) disable iff (rst)
    coef_valid && !coef_ready |=> coef_valid && $stable(coef_data))
    else begin
      fail_count++;
      $error("coef_valid dropped or coef_data changed before coef_ready");
    end

  // A full FIFO with no pop must stay full
  a_lag_full: assert property (@(posedge clk) disable iff (rst)
    lag_count == `LAG_FIFO_DEPTH && !(lag_out_valid && lag_out_ready)
    |=> lag_count == `LAG_FIFO_DEPTH)
    else begin
      fail_count++;
      $error("lag FIFO took a beat while full");
    end

  a_coef_full: assert property (@(posedge clk) disable iff (rst)
    beat_count == `COEF_FIFO_DEPTH && !(coef_valid && coef_ready)
    |=> beat_count == `COEF_FIFO_DEPTH)
    else begin
      fail_count++;
      $error("coefficient FIFO took a beat while full");
    end

  a_div_done: assert property (@(posedge clk) disable iff (rst)
    div_done |-> div_open)
    else begin
      fail_count++;
      $error("divider done without a pending start");
    end

endmodule

bind lpc_top lpc_properties lpc_properties_inst (
  .clk           (clk),
  .rst           (rst),
  .coef_valid    (coef_valid),
  .coef_ready    (coef_ready),
  .coef_data     (coef_data),
  .lag_out_valid (fifo_lag_valid),
  .lag_out_ready (fifo_lag_ready),
  .lag_count     (lag_fifo.count),
  .beat_count    (coef_fifo.count),
  .div_start     (levinson_ctrl.div_start),
  .div_done      (levinson_ctrl.div_done)
);

`default_nettype wire

//--- dv/lpc_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module lpc_checker (
  input  logic                clk,
  input  logic                rst,
  input  logic                coef_valid,
  input  logic                coef_ready,
  input  lpc_pkg::coef_beat_t coef_data,
  input  logic                frame_push,
  input  lpc_pkg::lag_t       frame_lags [0:`LPC_ORDER],
  input  logic                frame_err,
  output int                  frames_done,
  output int                  beat_checks,
  output int                  error_count
);

  import lpc_pkg::*;

  coef_beat_t exp_q [$];
  int         frame_beats;
  int         frame_errors;

  function automatic longint clip(input longint v, input longint lo, input longint hi);
    return (v > hi) ? hi : ((v < lo) ? lo : v);
  endfunction

  // Levinson-Durbin in 64-bit integers
  task automatic predict(input logic want_err);
    longint     a [0:`LPC_ORDER];
    longint     prev [0:`LPC_ORDER];
    longint     num;
    longint     den;
    longint     k;
    logic       bad;
    coef_beat_t beat;
    bad = 1'b0;
    foreach (a[i]) begin
      a[i] = 0;
    end
    a[0] = `COEF_ONE;
    for (int m = 1; m <= `LPC_ORDER && !bad; m++) begin
      num = 0;
      den = 0;
      for (int j = 0; j < m; j++) begin
        num += a[j] * frame_lags[m - j];
        den += a[j] * frame_lags[j];
      end
      if (den <= 0) begin
        bad = 1'b1;
      end else begin
        k    = clip(-(num * 32768) / den, -32767, 32767);
        prev = a;
        for (int j = 1; j < m; j++) begin
          a[j] = clip(prev[j] + ((k * prev[m - j] + 16384) >>> 15), -32768, 32767);
        end
        a[m] = k >>> 2;   // Q15 down to Q13
      end
    end
    for (int i = 1; i <= `LPC_ORDER; i++) begin
      beat.value = bad ? '0 : coef_t'(a[i]);
      beat.err   = bad;
      beat.last  = bad || (i == `LPC_ORDER);
      exp_q.push_back(beat);
      if (bad) begin
        break;
      end
    end
    if (bad != want_err) begin
      $display("%0t: frame table expects err=%0b, reference model gives err=%0b",
               $time, want_err, bad);
      error_count++;
    end
  endtask

  task automatic compare(input string name, input int want, input int got);
    if (want != got) begin
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, want, got);
      error_count++;
      frame_errors++;
    end
  endtask

  // Sampled mid-cycle, where valid, ready and data are settled
  always @(negedge clk) begin
    coef_beat_t want;
    if (rst) begin
      exp_q.delete();
      frames_done  = 0;
      beat_checks  = 0;
      error_count  = 0;
      frame_beats  = 0;
      frame_errors = 0;
    end else begin
      if (frame_push) begin
        predict(frame_err);
      end
      if (coef_valid && coef_ready) begin
        if (exp_q.size() == 0) begin
          $display("%0t: output beat arrived with no frame pending", $time);
          error_count++;
        end else begin
          want = exp_q.pop_front();
          beat_checks++;
          frame_beats++;
          compare("coef_data.value", int'($signed(want.value)), int'($signed(coef_data.value)));
          compare("coef_data.err", int'(want.err), int'(coef_data.err));
          compare("coef_data.last", int'(want.last), int'(coef_data.last));
          if (want.last) begin
            $display("Frame %0d done: %0d beats, %0d mismatches",
                     frames_done, frame_beats, frame_errors);
            frames_done++;
            frame_beats  = 0;
            frame_errors = 0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/lpc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lpc_cfg.svh"

module lpc_tb;

  import lpc_pkg::*;

  localparam int N_ROWS  = 9;
  localparam int SAMPLES = 32;

  logic       clk;
  logic       rst;
  logic       lag_valid;
  logic       lag_ready;
  lag_t       lag_data;
  logic       coef_valid;
  logic       coef_ready;
  coef_beat_t coef_data;
  logic       frame_push;
  lag_t       frame_lags [0:`LPC_ORDER];
  logic       frame_err;
  int         frames_done;
  int         beat_checks;
  int         error_count;
  int         tb_errors;
  int         prop_fails;
  logic       rand_ready;

  // Per-row frame table
  bit         row_rnd    [N_ROWS];
  lag_t       row_lags   [N_ROWS][0:`LPC_ORDER];
  bit         row_err    [N_ROWS];
  bit         row_toggle [N_ROWS];
  bit         row_drain  [N_ROWS];

  lpc_top lpc_top_inst (
    .clk        (clk),
    .rst        (rst),
    .lag_valid  (lag_valid),
    .lag_ready  (lag_ready),
    .lag_data   (lag_data),
    .coef_valid (coef_valid),
    .coef_ready (coef_ready),
    .coef_data  (coef_data)
  );

  lpc_checker checker_inst (
    .clk         (clk),
    .rst         (rst),
    .coef_valid  (coef_valid),
    .coef_ready  (coef_ready),
    .coef_data   (coef_data),
    .frame_push  (frame_push),
    .frame_lags  (frame_lags),
    .frame_err   (frame_err),
    .frames_done (frames_done),
    .beat_checks (beat_checks),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic set_row(input int r, input bit rnd, input bit err, input bit tgl,
                         input bit drain);
    row_rnd[r]    = rnd;
    row_err[r]    = err;
    row_toggle[r] = tgl;
    row_drain[r]  = drain;
    for (int i = 0; i <= `LPC_ORDER; i++) begin
      row_lags[r][i] = '0;
    end
  endtask

  task automatic load_table();
    set_row(0, 0, 0, 0, 1);
    row_lags[0] = '{16384, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};   // Impulse
    set_row(1, 0, 0, 0, 1);
    row_lags[1] = '{16384, 8192, 4096, 2048, 1024, 512, 256, 128, 64, 32, 16};
    set_row(2, 1, 0, 1, 1);
    set_row(3, 1, 0, 0, 1);
    set_row(4, 1, 0, 1, 1);
    set_row(5, 0, 1, 0, 1);
    row_lags[5] = '{0, 300, -200, 0, 0, 0, 0, 0, 0, 0, 0};   // R0 zero
    set_row(6, 0, 0, 1, 1);
    row_lags[6] = '{12000, 3000, 750, 187, 46, 11, 2, 0, 0, 0, 0};
    set_row(7, 1, 0, 1, 0);   // Back to back with row 8
    set_row(8, 1, 0, 1, 1);
  endtask

  // Autocorrelation of random 8-bit samples
  task automatic make_lags(input int r);
    int     x [0:SAMPLES-1];
    longint acc;
    for (int i = 0; i < SAMPLES; i++) begin
      x[i] = int'($urandom % 256) - 128;
    end
    for (int l = 0; l <= `LPC_ORDER; l++) begin
      acc = 0;
      for (int i = l; i < SAMPLES; i++) begin
        acc += x[i] * x[i - l];
      end
      row_lags[r][l] = lag_t'(acc >>> 5);   // R0 stays within 16 bits
    end
  endtask

  task automatic push_lag(input lag_t value);
    logic taken;
    lag_valid = 1'b1;
    lag_data  = value;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = lag_ready;
      @(posedge clk);
      #1;
    end
    lag_valid = 1'b0;
  endtask

  task automatic drive_frame(input int r);
    frame_lags = row_lags[r];
    frame_err  = row_err[r];
    frame_push = 1'b1;
    @(posedge clk);
    #1;
    frame_push = 1'b0;
    for (int i = 0; i <= `LPC_ORDER; i++) begin
      push_lag(row_lags[r][i]);
    end
  endtask

  // Output sink samples its mode at the clock edge
  initial begin
    logic toggle;
    coef_ready = 1'b1;
    forever begin
      @(posedge clk);
      toggle = rand_ready;
      #1;
      coef_ready = toggle ? 1'($urandom % 2) : 1'b1;
    end
  end

  initial begin
    repeat (N_ROWS * 2000) @(posedge clk);
    $display("Timeout: frames still outstanding after %0d cycles", N_ROWS * 2000);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    void'($urandom(67));
    rst        = 1'b1;
    lag_valid  = 1'b0;
    lag_data   = '0;
    frame_push = 1'b0;
    frame_err  = 1'b0;
    rand_ready = 1'b0;
    tb_errors  = 0;
    foreach (frame_lags[i]) begin
      frame_lags[i] = '0;
    end
    load_table();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (coef_valid !== 1'b0) begin
      $display("[FAIL] %0t coef_valid expected 0 got %b", $time, coef_valid);
      tb_errors++;
    end
    if (lag_ready !== 1'b1) begin
      $display("[FAIL] %0t lag_ready expected 1 got %b", $time, lag_ready);
      tb_errors++;
    end
    $display("Reset state checked");
    @(posedge clk);
    #1;
    for (int r = 0; r < N_ROWS; r++) begin
      if (row_rnd[r]) begin
        make_lags(r);
      end
      rand_ready = row_toggle[r];
      drive_frame(r);
      if (row_drain[r]) begin
        wait (frames_done == r + 1);
        @(posedge clk);
        #1;
      end
    end
    repeat (5) @(posedge clk);
    prop_fails = lpc_top_inst.lpc_properties_inst.fail_count;
    $display("Frames %0d of %0d, beats checked %0d, errors %0d, assertion failures %0d",
             frames_done, N_ROWS, beat_checks, error_count + tb_errors, prop_fails);
    if (error_count == 0 && tb_errors == 0 && prop_fails == 0 && frames_done == N_ROWS) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/lpc_pkg.sv
logic/stream_fifo.sv
logic/corr_mac.sv
logic/fixed_divider.sv
logic/coeff_update.sv
logic/levinson_ctrl.sv
logic/lpc_top.sv
dv/lpc_properties.sv
dv/lpc_checker.sv
dv/lpc_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lpc_tb -f src.f -o lpc_sim \
  && ./obj_dir/lpc_sim +verilator+error+limit+100 | tee /dev/stderr | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
